// ==== Makefile ====
SIM_TOOL := verilator
FLAGS    := --binary --assert --timing
TOP      := tb_uart_bridge
FILELIST := files.f
OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM_TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG) || ! grep -q "all tests passed" $(LOG); then \
	  exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
uart_pkg.sv
uart_cmd_sequencer.sv
uart_tx_frame.sv
uart_rx_frame.sv
uart_bridge.sv
uart_bridge_checker.sv
tb_uart_bridge.sv

// ==== tb_uart_bridge.sv ====
`timescale 1ns/1ps

module tb_uart_bridge;
  import uart_pkg::*;

  localparam int clks_per_bit = 16;
  // a command needs about 22 bit times
  localparam int wait_limit = 30 * clks_per_bit;

  logic                 clk;
  logic                 rst_n;
  logic [cmd_width-1:0] cmd_in;
  logic                 cmd_vld;
  logic                 cmd_rdy;
  logic                 rx;
  logic                 tx;
  logic [data_width:0]  read_data;
  logic                 read_rdy;
  int                   error_count;
  int                   seed;
  logic [31:0]          r;
  logic [cmd_width-1:0] directed[4];

  uart_bridge #(.clks_per_bit(clks_per_bit)) u_uart_bridge (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

  uart_bridge_checker #(.clks_per_bit(clks_per_bit)) u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .tx          (tx),
    .cmd_in      (cmd_in),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .read_data   (read_data),
    .read_rdy    (read_rdy),
    .error_count (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic wait_cmd_rdy();
    int n;
    n = 0;
    while (!cmd_rdy && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy) u_checker.note_failure("timed out waiting for cmd_rdy");
  endtask

  task automatic issue_cmd(input logic [cmd_width-1:0] cmd);
    wait_cmd_rdy();
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  // lands somewhere inside the running command
  task automatic strobe_while_busy();
    r = $random(seed);
    repeat (int'(r[6:0]) + 1) @(negedge clk);
    if (!cmd_rdy) begin
      cmd_in  = r[31:16];
      cmd_vld = 1'b1;
      @(negedge clk);
      cmd_vld = 1'b0;
    end
  endtask

  task automatic serialize_rx(input logic [data_width-1:0] data, input logic bad_par,
                              input logic bad_stop);
    logic [frame_bits-1:0] frame;
    logic                  seen;
    int                    i;
    int                    n;
    u_checker.queue_read(data, bad_par, bad_stop);
    frame = {!bad_stop, !(^data) ^ bad_par, data, 1'b0};
    for (i = 0; i < frame_bits - 1; i++) begin
      rx = frame[i];
      repeat (clks_per_bit) @(negedge clk);
    end
    // read_rdy should show up mid stop bit
    rx   = frame[frame_bits-1];
    seen = 1'b0;
    repeat (clks_per_bit) begin
      @(negedge clk);
      if (read_rdy) seen = 1'b1;
    end
    rx = 1'b1;
    n  = 0;
    while (!seen && n < 2 * clks_per_bit) begin
      @(negedge clk);
      seen = read_rdy;
      n++;
    end
    if (!seen) u_checker.note_failure("timed out waiting for read_rdy");
    repeat (clks_per_bit) @(negedge clk);
  endtask

  initial begin
    seed     = 32'h52a0ee5f;
    rst_n    = 1'b0;
    cmd_in   = '0;
    cmd_vld  = 1'b0;
    rx       = 1'b1;
    directed = '{16'h0000, 16'hffff, 16'ha55a, 16'h8001};
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    u_checker.check_idle();
    repeat (4 * clks_per_bit) @(negedge clk);
    u_checker.end_test("reset_state");

    foreach (directed[i]) begin
      issue_cmd(directed[i]);
      wait_cmd_rdy();
    end
    u_checker.end_test("directed_commands");

    repeat (20) begin
      r = $random(seed);
      issue_cmd(r[15:0]);
      strobe_while_busy();
    end
    wait_cmd_rdy();
    u_checker.end_test("random_commands");

    repeat (8) begin
      r = $random(seed);
      serialize_rx(r[7:0], 1'b0, 1'b0);
    end
    u_checker.end_test("good_receive");

    repeat (4) begin
      r = $random(seed);
      serialize_rx(r[7:0], 1'b1, 1'b0);
    end
    u_checker.end_test("bad_parity");

    // each bad frame is followed by a clean one
    repeat (4) begin
      r = $random(seed);
      serialize_rx(r[7:0], 1'b0, 1'b1);
      serialize_rx(r[15:8], 1'b0, 1'b0);
    end
    u_checker.end_test("bad_stop_recovery");

    u_checker.report();
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== uart_bridge.sv ====
`timescale 1ns/1ps

module uart_bridge #(
  parameter int clks_per_bit = 434
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [uart_pkg::cmd_width-1:0] cmd_in,
  input  logic                           cmd_vld,
  output logic                           cmd_rdy,
  input  logic                           rx,
  output logic                           tx,
  output logic [uart_pkg::data_width:0]  read_data,
  output logic                           read_rdy
);
  import uart_pkg::*;

  // sequencer to transmitter
  logic [data_width-1:0] byte_data;
  logic                  byte_start;
  logic                  byte_done;

  uart_cmd_sequencer u_cmd_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .byte_done  (byte_done),
    .cmd_rdy    (cmd_rdy),
    .byte_data  (byte_data),
    .byte_start (byte_start)
  );

  uart_tx_frame #(
    .clks_per_bit (clks_per_bit)
  ) u_tx_frame (
    .clk        (clk),
    .rst_n      (rst_n),
    .byte_data  (byte_data),
    .byte_start (byte_start),
    .tx         (tx),
    .byte_done  (byte_done)
  );

  uart_rx_frame #(
    .clks_per_bit (clks_per_bit)
  ) u_rx_frame (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

endmodule

// ==== uart_bridge_checker.sv ====
`timescale 1ns/1ps

module uart_bridge_checker #(
  parameter int clks_per_bit = 16
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           tx,
  input  logic [uart_pkg::cmd_width-1:0] cmd_in,
  input  logic                           cmd_vld,
  input  logic                           cmd_rdy,
  input  logic [uart_pkg::data_width:0]  read_data,
  input  logic                           read_rdy,
  output int                             error_count
);
  import uart_pkg::*;

  logic [data_width-1:0] tx_expect[$];
  logic [data_width:0]   rx_expect[$];
  logic [data_width-1:0] hi_byte;
  logic [data_width-1:0] lo_byte;
  logic [data_width:0]   exp_read;
  logic                  accepted;
  int                    checks;
  int                    errors;
  int                    tests;
  int                    failing;
  int                    total_errors;

  assign error_count = total_errors;

  // high byte leaves first
  function automatic void split_cmd(input logic [cmd_width-1:0] cmd,
                                    output logic [data_width-1:0] first,
                                    output logic [data_width-1:0] second);
    first  = cmd[cmd_width-1:data_width];
    second = cmd[data_width-1:0];
  endfunction

  // stop, odd parity, data lsb first, start
  function automatic logic [frame_bits-1:0] frame_for(input logic [data_width-1:0] b);
    int ones;
    int i;
    ones = 0;
    for (i = 0; i < data_width; i++) begin
      if (b[i]) ones++;
    end
    return {1'b1, (ones % 2) == 0, b, 1'b0};
  endfunction

  function automatic logic [data_width:0] read_for(input logic [data_width-1:0] b,
                                                   input logic bad_par, input logic bad_stop);
    return {bad_par | bad_stop, b};
  endfunction

  task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    end
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("error: %s", msg);
  endtask

  task automatic queue_read(input logic [data_width-1:0] b, input logic bad_par,
                            input logic bad_stop);
    rx_expect.push_back(read_for(b, bad_par, bad_stop));
  endtask

  task automatic check_idle();
    compare("tx", 16'd1, 16'(tx));
    compare("cmd_rdy", 16'd1, 16'(cmd_rdy));
    compare("read_rdy", 16'd0, 16'(read_rdy));
    compare("read_data", 16'd0, 16'(read_data));
  endtask

  task automatic end_test(input string name);
    if (tx_expect.size() != 0) begin
      note_failure($sformatf("%0d tx frames never appeared", tx_expect.size()));
    end
    if (rx_expect.size() != 0) begin
      note_failure($sformatf("%0d read_rdy pulses never came", rx_expect.size()));
    end
    tx_expect.delete();
    rx_expect.delete();
    tests++;
    total_errors += errors;
    if (errors != 0) failing++;
    $display("test %s: %s, %0d checks, %0d errors", name, (errors == 0) ? "pass" : "FAIL",
             checks, errors);
    checks = 0;
    errors = 0;
  endtask

  task automatic report();
    $display("summary: %0d tests run, %0d failing, %0d errors", tests, failing, total_errors);
  endtask

  // first low cycle seen, then step to the middle of each bit
  task automatic decode_frame();
    logic [frame_bits-1:0] bits;
    logic [frame_bits-1:0] exp;
    int i;
    repeat (clks_per_bit / 2 - 1) @(posedge clk);
    bits[0] = tx;
    for (i = 1; i < frame_bits; i++) begin
      repeat (clks_per_bit) @(posedge clk);
      bits[i] = tx;
    end
    if (tx_expect.size() == 0) begin
      note_failure($sformatf("frame on tx with no command pending, data 0x%0h", bits[8:1]));
    end else begin
      exp = frame_for(tx_expect.pop_front());
      compare("tx start bit", 16'(exp[0]), 16'(bits[0]));
      compare("tx data", 16'(exp[8:1]), 16'(bits[8:1]));
      compare("tx parity", 16'(exp[9]), 16'(bits[9]));
      compare("tx stop bit", 16'(exp[10]), 16'(bits[10]));
    end
  endtask

  initial begin
    forever begin
      @(posedge clk);
      if (rst_n === 1'b1 && tx === 1'b0) decode_frame();
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      accepted = 1'b0;
    end else begin
      // cmd_rdy drops right after an accepted command
      if (accepted) compare("cmd_rdy", 16'd0, 16'(cmd_rdy));
      accepted = cmd_vld && cmd_rdy;
      if (accepted) begin
        split_cmd(cmd_in, hi_byte, lo_byte);
        tx_expect.push_back(hi_byte);
        tx_expect.push_back(lo_byte);
      end
      if (read_rdy) begin
        if (rx_expect.size() == 0) begin
          note_failure("read_rdy pulse with no frame sent on rx");
        end else begin
          exp_read = rx_expect.pop_front();
          compare("read_data", 16'(exp_read), 16'(read_data));
        end
      end
    end
  end

endmodule

// ==== uart_cmd_sequencer.sv ====
`timescale 1ns/1ps

module uart_cmd_sequencer (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [uart_pkg::cmd_width-1:0]  cmd_in,
  input  logic                            cmd_vld,
  input  logic                            byte_done,
  output logic                            cmd_rdy,
  output logic [uart_pkg::data_width-1:0] byte_data,
  output logic                            byte_start
);
  import uart_pkg::*;

  seq_state_t           state;
  seq_state_t           state_nxt;
  logic [cmd_width-1:0] cmd_reg;
  logic                 accept;

  assign accept = cmd_vld && cmd_rdy;

  always_comb begin
    state_nxt = state;
    case (state)
      seq_idle: begin
        if (accept) begin
          state_nxt = seq_send_hi;
        end
      end
      seq_send_hi: state_nxt = seq_wait_hi;
      seq_wait_hi: begin
        if (byte_done) begin
          state_nxt = seq_send_lo;
        end
      end
      seq_send_lo: state_nxt = seq_wait_lo;
      seq_wait_lo: begin
        if (byte_done) begin
          state_nxt = seq_idle;
        end
      end
      default: state_nxt = seq_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= seq_idle;
      cmd_rdy <= 1'b1;
    end else begin
      state <= state_nxt;
      if (accept) begin
        cmd_rdy <= 1'b0;
      end else if (state == seq_wait_lo && byte_done) begin
        cmd_rdy <= 1'b1;
      end
    end
  end

  // command held until the low byte has gone out
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_reg <= cmd_in;
    end
  end

  assign byte_start = (state == seq_send_hi) || (state == seq_send_lo);
  assign byte_data  = (state == seq_send_lo) ? cmd_reg[data_width-1:0]
                                             : cmd_reg[cmd_width-1 -: data_width];

  a_rdy_only_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy == (state == seq_idle));

  a_start_gap: assert property (@(posedge clk) disable iff (!rst_n)
    byte_start |=> !byte_start);

endmodule

// ==== uart_pkg.sv ====
package uart_pkg;

  // command and character sizes
  parameter int cmd_width  = 16;
  parameter int data_width = 8;

  // start + 8 data + parity + stop
  parameter int frame_bits = 11;

  typedef enum logic [2:0] {
    seq_idle,
    seq_send_hi,
    seq_wait_hi,
    seq_send_lo,
    seq_wait_lo
  } seq_state_t;

  typedef enum logic [2:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_parity,
    tx_stop
  } tx_state_t;

  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_parity,
    rx_stop
  } rx_state_t;

  // one when the byte holds an even number of ones
  function automatic logic odd_parity(input logic [data_width-1:0] d);
    return ~^d;
  endfunction

endpackage

// ==== uart_rx_frame.sv ====
`timescale 1ns/1ps

module uart_rx_frame #(
  parameter int clks_per_bit = 434
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          rx,
  output logic [uart_pkg::data_width:0] read_data,
  output logic                          read_rdy
);
  import uart_pkg::*;

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam int bit_w = $clog2(frame_bits);
  localparam logic [cnt_w-1:0] last_cnt  = cnt_w'(clks_per_bit - 1);
  localparam logic [cnt_w-1:0] half_cnt  = cnt_w'(clks_per_bit / 2 - 1);
  localparam logic [bit_w-1:0] last_data = bit_w'(data_width);

  rx_state_t             state;
  logic                  rx_meta;
  logic                  rx_sync;
  logic                  rx_prev;
  logic [cnt_w-1:0]      clk_cnt;
  logic [bit_w-1:0]      bit_cnt;
  logic [data_width-1:0] shreg;
  logic                  par_err;
  logic                  fall;
  logic                  mid_bit;

  // two-flop synchronizer, line idles high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall    = rx_prev && !rx_sync;
  assign mid_bit = clk_cnt == last_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= rx_idle;
      clk_cnt   <= '0;
      bit_cnt   <= '0;
      read_data <= '0;
      read_rdy  <= 1'b0;
    end else begin
      read_rdy <= 1'b0;
      clk_cnt  <= clk_cnt + 1'b1;
      case (state)
        rx_idle: begin
          clk_cnt <= '0;
          if (fall) begin
            state <= rx_start;
          end
        end
        rx_start: begin
          // half-bit offset, then full bit steps from the start middle
          if (clk_cnt == half_cnt) begin
            clk_cnt <= '0;
            bit_cnt <= 'd1;
            state   <= rx_sync ? rx_idle : rx_data;
          end
        end
        rx_data: begin
          if (mid_bit) begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == last_data) begin
              state <= rx_parity;
            end
          end
        end
        rx_parity: begin
          if (mid_bit) begin
            clk_cnt <= '0;
            state   <= rx_stop;
          end
        end
        rx_stop: begin
          if (mid_bit) begin
            read_data <= {par_err | !rx_sync, shreg};
            read_rdy  <= 1'b1;
            state     <= rx_idle;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  // lsb first, so new bits enter at the top
  always_ff @(posedge clk) begin
    if (state == rx_data && mid_bit) begin
      shreg <= {rx_sync, shreg[data_width-1:1]};
    end
    if (state == rx_parity && mid_bit) begin
      par_err <= rx_sync ^ odd_parity(shreg);
    end
  end

  a_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy);

endmodule

// ==== uart_tx_frame.sv ====
`timescale 1ns/1ps

module uart_tx_frame #(
  parameter int clks_per_bit = 434
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [uart_pkg::data_width-1:0] byte_data,
  input  logic                            byte_start,
  output logic                            tx,
  output logic                            byte_done
);
  import uart_pkg::*;

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam int bit_w = $clog2(frame_bits);
  localparam logic [cnt_w-1:0] last_cnt  = cnt_w'(clks_per_bit - 1);
  localparam logic [bit_w-1:0] last_data = bit_w'(data_width);

  tx_state_t           state;
  logic [cnt_w-1:0]    clk_cnt;
  logic [bit_w-1:0]    bit_cnt;
  logic [data_width:0] shreg;
  logic                bit_end;

  assign bit_end   = (state != tx_idle) && (clk_cnt == last_cnt);
  assign byte_done = (state == tx_stop) && (clk_cnt == last_cnt);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= tx_idle;
      clk_cnt <= '0;
      bit_cnt <= '0;
      tx      <= 1'b1;
    end else if (state == tx_idle) begin
      if (byte_start) begin
        state   <= tx_start;
        clk_cnt <= '0;
        bit_cnt <= '0;
        tx      <= 1'b0;
      end
    end else if (!bit_end) begin
      clk_cnt <= clk_cnt + 1'b1;
    end else begin
      clk_cnt <= '0;
      bit_cnt <= bit_cnt + 1'b1;
      case (state)
        tx_start: begin
          tx    <= shreg[0];
          state <= tx_data;
        end
        tx_data: begin
          // after the last data bit shreg[0] is the parity bit
          tx <= shreg[0];
          if (bit_cnt == last_data) begin
            state <= tx_parity;
          end
        end
        tx_parity: begin
          tx    <= 1'b1;
          state <= tx_stop;
        end
        default: state <= tx_idle;
      endcase
    end
  end

  // parity rides above the data so it shifts out right after bit 7
  always_ff @(posedge clk) begin
    if (state == tx_idle && byte_start) begin
      shreg <= {odd_parity(byte_data), byte_data};
    end else if (bit_end && (state == tx_start || state == tx_data)) begin
      shreg <= shreg >> 1;
    end
  end

  a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    byte_start |-> state == tx_idle);

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    byte_done |=> !byte_done);

endmodule
